// ==== list.f ====
logic/uartPkg.sv
logic/rxByteIf.sv
logic/rxLineConditioner.sv
logic/uartReceive.sv
logic/byteCollector.sv
logic/uartRxHub.sv
verification/uartRxHub_properties.sv
verification/uartRxHub_tb.sv

// ==== logic/byteCollector.sv ====
module byteCollector (
  input  logic                            clk,
  input  logic                            reset,
  rxByteIf.collector                      chanPorts [uartPkg::numChannels-1:0],
  input  logic                            creditReturn,
  output logic                            outValid,
  output logic [uartPkg::channelBits-1:0] outChannel,
  output logic [7:0]                      outData,
  output logic                            outFrameError,
  output logic                            outOverrun
);
  import uartPkg::*;

  logic [numChannels-1:0] validVec;       // Which receivers hold a byte
  logic [numChannels-1:0] takenVec;       // One-hot pop, or zero
  logic [7:0]             chanData [numChannels];
  logic [numChannels-1:0] chanFrameError;
  logic [numChannels-1:0] chanOverrun;
  logic [channelBits-1:0] lastGrant;      // Round-robin pointer
  logic [channelBits-1:0] pick;           // Next valid channel after the pointer
  logic                   found;
  logic                   grant;
  logic [creditBits-1:0]  credit;         // Bytes the consumer can still accept

  // Flatten the interface array so it can be indexed by a variable
  genvar g;
  generate
    for (g = 0; g < numChannels; g++)
    begin : genTap
      assign validVec[g]        = chanPorts[g].valid;
      assign chanData[g]        = chanPorts[g].data;
      assign chanFrameError[g]  = chanPorts[g].frameError;
      assign chanOverrun[g]     = chanPorts[g].overrun;
      assign chanPorts[g].taken = takenVec[g];
    end
  endgenerate

  // Search starts one past the last grant and wraps
  always_comb
  begin
    found = 1'b0;
    pick  = lastGrant;
    for (int k = 1; k <= numChannels; k++)
    begin
      if (!found && validVec[(lastGrant + k) % numChannels])
      begin
        found = 1'b1;
        pick  = channelBits'((lastGrant + k) % numChannels);
      end
    end
  end

  assign grant    = found && (credit != '0); // Back-pressure leaves bytes in the receivers
  assign takenVec = grant ? (numChannels'(1) << pick) : '0;

  // Pointer, credit and output strobe
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      outValid  <= 1'b0;
      lastGrant <= channelBits'(numChannels - 1); // Channel 0 goes first
      credit    <= creditBits'(creditLimit);
    end
    else
    begin
      outValid <= grant;
      if (grant)
        lastGrant <= pick;
      case ({grant, creditReturn})
        2'b10:   credit <= credit - 1'b1; // Spend only
        2'b01:   credit <= credit + 1'b1; // Return only
        default: credit <= credit;        // Both or neither cancel out
      endcase
    end
  end

  // Output byte and tags, qualified by outValid
  always_ff @(posedge clk)
  begin
    if (grant)
    begin
      outChannel    <= pick;
      outData       <= chanData[pick];
      outFrameError <= chanFrameError[pick];
      outOverrun    <= chanOverrun[pick];
    end
  end

endmodule

// ==== logic/rxByteIf.sv ====
// One received byte handed from a receiver to the collector
interface rxByteIf;

  logic       valid;      // Holding register is full
  logic [7:0] data;       // Received byte, LSB first on the wire
  logic       frameError; // Stop bit was sampled low
  logic       overrun;    // A later byte was lost while this one waited
  logic       taken;      // One-cycle pop from the collector

  modport receiver (
    output valid,
    output data,
    output frameError,
    output overrun,
    input  taken
  );

  modport collector (
    input  valid,
    input  data,
    input  frameError,
    input  overrun,
    output taken
  );

endinterface

// ==== logic/rxLineConditioner.sv ====
module rxLineConditioner (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [uartPkg::numChannels-1:0] rxd,
  output logic [uartPkg::numChannels-1:0] lineClean
);
  import uartPkg::*;

  logic [numChannels-1:0] syncFirst;  // First flop, may go metastable
  logic [numChannels-1:0] syncSecond; // Safe to use from here on
  logic [numChannels-1:0] histNew;    // Previous synchronized sample
  logic [numChannels-1:0] histOld;    // Sample before that

  // All stages come out of reset at the idle line level
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      syncFirst  <= '1;
      syncSecond <= '1;
      histNew    <= '1;
      histOld    <= '1;
    end
    else
    begin
      syncFirst  <= rxd;
      syncSecond <= syncFirst;
      histNew    <= syncSecond;
      histOld    <= histNew;
    end
  end

  // Two of three samples must agree
  // A one-cycle glitch only ever occupies one slot of the window
  always_comb
  begin
    for (int i = 0; i < numChannels; i++)
    begin
      lineClean[i] = (syncSecond[i] & histNew[i]) |
                     (syncSecond[i] & histOld[i]) |
                     (histNew[i] & histOld[i]);
    end
  end

endmodule

// ==== logic/uartPkg.sv ====
package uartPkg;

  // Serial lines handled by the hub
  localparam int numChannels = 4;
  localparam int channelBits = 2;   // Width of a channel number

  // Bit timing on the conditioned line
  localparam int clocksPerBit = 16; // Kept short so simulation runs quickly
  localparam int halfBit = clocksPerBit / 2; // Low time that confirms a start bit

  // Bytes the consumer can take before it must hand credit back
  localparam int creditLimit = 4;
  localparam int creditBits = 3;    // Holds 0 up to creditLimit

  // Receiver FSM states
  typedef enum logic [1:0] {
    idle,   // Waiting for the line to drop
    start,  // Confirming the start bit
    data,   // Shifting in the eight data bits
    stop    // Waiting for the stop sample
  } rxState;

endpackage

// ==== logic/uartReceive.sv ====
module uartReceive (
  input  logic      clk,
  input  logic      reset,
  input  logic      line,   // Conditioned serial input
  rxByteIf.receiver rxPort
);
  import uartPkg::*;

  rxState state;
  logic [$clog2(clocksPerBit)-1:0] cycleCnt; // Clocks within the current bit
  logic [2:0] bitCnt;          // Data bit being received
  logic [7:0] shiftReg;        // Byte under assembly
  logic       waitHigh;        // Set after a framing error until the line recovers
  logic       bitEdge;         // Sample point of a data or stop bit
  logic       byteDone;        // Stop bit sampled this cycle

  // One-byte holding register toward the collector
  logic       holdValid;
  logic [7:0] holdData;
  logic       holdFrameError;
  logic       holdOverrun;

  assign bitEdge  = (cycleCnt == clocksPerBit - 1);
  assign byteDone = (state == stop) && bitEdge;

  // Receive FSM
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state    <= idle;
      cycleCnt <= '0;
      bitCnt   <= '0;
      waitHigh <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
        begin
          cycleCnt <= $bits(cycleCnt)'(1); // The falling sample counts as the first low
          bitCnt   <= '0;
          if (waitHigh)
          begin
            if (line)
              waitHigh <= 1'b0;       // Line back at idle level, rearm
          end
          else if (!line)
            state <= start;
        end
        start:
        begin
          if (line)
            state <= idle;            // Too short for a start bit
          else if (cycleCnt == halfBit - 1)
          begin
            state    <= data;         // Now near the middle of the start bit
            cycleCnt <= '0;
          end
          else
            cycleCnt <= cycleCnt + 1'b1;
        end
        data:
        begin
          if (bitEdge)
          begin
            cycleCnt <= '0;
            bitCnt   <= bitCnt + 1'b1;
            if (bitCnt == 3'd7)
              state <= stop;
          end
          else
            cycleCnt <= cycleCnt + 1'b1;
        end
        stop:
        begin
          if (bitEdge)
          begin
            state    <= idle;
            waitHigh <= !line;        // Low stop bit, hold off until a high line
          end
          else
            cycleCnt <= cycleCnt + 1'b1;
        end
        default: state <= idle;
      endcase
    end
  end

  // Holding register occupancy
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      holdValid <= 1'b0;
    else if (byteDone)
      holdValid <= 1'b1;              // Either newly loaded or still full
    else if (rxPort.taken)
      holdValid <= 1'b0;
  end

  // Shift register and held byte
  always_ff @(posedge clk)
  begin
    if (state == data && bitEdge)
      shiftReg <= {line, shiftReg[7:1]}; // LSB arrives first
    if (byteDone)
    begin
      if (holdValid && !rxPort.taken)
        holdOverrun <= 1'b1;          // New byte dropped, older one flagged
      else
      begin
        holdData       <= shiftReg;
        holdFrameError <= !line;
        holdOverrun    <= 1'b0;
      end
    end
  end

  assign rxPort.valid      = holdValid;
  assign rxPort.data       = holdData;
  assign rxPort.frameError = holdFrameError;
  assign rxPort.overrun    = holdOverrun;

endmodule

// ==== logic/uartRxHub.sv ====
module uartRxHub (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [uartPkg::numChannels-1:0] rxd,
  input  logic                            creditReturn,
  output logic                            outValid,
  output logic [uartPkg::channelBits-1:0] outChannel,
  output logic [7:0]                      outData,
  output logic                            outFrameError,
  output logic                            outOverrun
);
  import uartPkg::*;

  logic [numChannels-1:0] lineClean; // Synchronized, deglitched lines

  // One byte link per channel
  rxByteIf rxLink [numChannels-1:0] ();

  rxLineConditioner i_lineConditioner (
    .clk       (clk),
    .reset     (reset),
    .rxd       (rxd),
    .lineClean (lineClean)
  );

  genvar g;
  generate
    for (g = 0; g < numChannels; g++)
    begin : genChannel
      uartReceive i_uartReceive (
        .clk    (clk),
        .reset  (reset),
        .line   (lineClean[g]),
        .rxPort (rxLink[g])
      );
    end
  endgenerate

  byteCollector i_byteCollector (
    .clk           (clk),
    .reset         (reset),
    .chanPorts     (rxLink),
    .creditReturn  (creditReturn),
    .outValid      (outValid),
    .outChannel    (outChannel),
    .outData       (outData),
    .outFrameError (outFrameError),
    .outOverrun    (outOverrun)
  );

endmodule

// ==== verification/uartRxHub_properties.sv ====
module uartRxHub_properties (
  input logic                            clk,
  input logic                            reset,
  input logic                            outValid,
  input logic                            creditReturn,
  input logic [uartPkg::creditBits-1:0]  credit,
  input logic [uartPkg::numChannels-1:0] validVec,
  input logic [uartPkg::numChannels-1:0] takenVec
);
  timeunit 1ns;
  timeprecision 1ps;
  import uartPkg::*;

  int failCount = 0; // Assertion failures seen so far

  // Empty counter with nothing coming back blocks the next strobe
  noCreditNoValid: assert property (@(posedge clk) disable iff (reset)
    (credit == '0 && !creditReturn) |=> !outValid)
    else
    begin
      $error("outValid followed a cycle with zero credit");
      failCount++;
    end

  creditBounded: assert property (@(posedge clk) disable iff (reset)
    credit <= creditBits'(creditLimit))
    else
    begin
      $error("Credit counter above its limit");
      failCount++;
    end

  takenOneHot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(takenVec))
    else
    begin
      $error("More than one channel popped in a cycle");
      failCount++;
    end

  takenNeedsValid: assert property (@(posedge clk) disable iff (reset)
    (takenVec & ~validVec) == '0)
    else
    begin
      $error("Pop sent to a channel with an empty holding register");
      failCount++;
    end

endmodule

bind byteCollector uartRxHub_properties i_collectorProps (
  .clk          (clk),
  .reset        (reset),
  .outValid     (outValid),
  .creditReturn (creditReturn),
  .credit       (credit),
  .validVec     (validVec),
  .takenVec     (takenVec)
);

// ==== verification/uartRxHub_tb.sv ====
module uartRxHub_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import uartPkg::*;

  localparam int maxRecords = 64;

  logic                   clk = 1'b0;
  logic                   reset;
  logic [numChannels-1:0] rxd;
  logic                   creditReturn;
  logic                   outValid;
  logic [channelBits-1:0] outChannel;
  logic [7:0]             outData;
  logic                   outFrameError;
  logic                   outOverrun;

  logic [23:0] records [maxRecords]; // Op, channel, byte, stop level, flags
  int          numRecords;
  logic [15:0] expQ [$];             // Op tag, channel, overrun, frame error, byte
  int          recQ [$];             // Record number of each expected byte
  logic [7:0]  gData [numChannels];  // Concurrent group being gathered
  logic        gStop [numChannels];
  logic        gUse [numChannels];
  logic [31:0] rngState;
  logic        holdCredit;           // Consumer keeps its credit while set
  int          outstanding;          // Bytes received and not yet paid back
  int          errorCount;
  int          checkedCount;
  int          matchIdx;
  logic [15:0] expEntry;

  uartRxHub i_uartRxHub (
    .clk           (clk),
    .reset         (reset),
    .rxd           (rxd),
    .creditReturn  (creditReturn),
    .outValid      (outValid),
    .outChannel    (outChannel),
    .outData       (outData),
    .outFrameError (outFrameError),
    .outOverrun    (outOverrun)
  );

  always #10 clk = ~clk; // 20 ns period

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic string testName(input logic [3:0] tag);
    case (tag)
      4'd1:    return "single frame";
      4'd2:    return "concurrent group";
      4'd3:    return "credit hold";
      default: return "unknown";
    endcase
  endfunction

  // Oldest expected byte of one channel, or -1
  function automatic int findExpected(input logic [channelBits-1:0] ch);
    for (int i = 0; i < expQ.size(); i++)
    begin
      if (expQ[i][11:10] == ch)
        return i;
    end
    return -1;
  endfunction

  task automatic pushExpected(input logic [23:0] rec, input int recNum);
    logic [3:0] tag;
    tag = holdCredit ? 4'd3 : rec[23:20];
    if (!rec[3]) // Flag bit 3 marks a byte the DUT must drop
    begin
      expQ.push_back({tag, rec[17:16], rec[1], rec[0], rec[15:8]});
      recQ.push_back(recNum);
    end
  endtask

  task automatic driveBit(input int ch, input logic level);
    @(posedge clk);
    rxd[ch] <= level;
    repeat (clocksPerBit - 1) @(posedge clk);
  endtask

  // Start bit, eight data bits LSB first, stop bit
  task automatic sendFrame(input int ch, input logic [7:0] value, input logic stopLevel);
    driveBit(ch, 1'b0);
    for (int i = 0; i < 8; i++)
      driveBit(ch, value[i]);
    driveBit(ch, stopLevel);
    @(posedge clk);
    rxd[ch] <= 1'b1; // Idle level ends the stop bit
  endtask

  task automatic sendGlitch(input int ch, input logic [7:0] width);
    @(posedge clk);
    rxd[ch] <= 1'b0;
    repeat (width) @(posedge clk);
    rxd[ch] <= 1'b1;
    repeat (10 * clocksPerBit) @(posedge clk); // Room for a false byte to show up
  endtask

  task automatic idleGap();
    rngState = xorshift(rngState);
    repeat (clocksPerBit + rngState % clocksPerBit) @(posedge clk); // One to two bits
  endtask

  task automatic waitDrain();
    while (expQ.size() != 0)
      @(posedge clk); // Until every expected byte is checked
  endtask

  task automatic launchChannel(input int ch);
    if (gUse[ch])
      sendFrame(ch, gData[ch], gStop[ch]);
  endtask

  task automatic launchGroup();
    fork
      launchChannel(0);
      launchChannel(1);
      launchChannel(2);
      launchChannel(3);
    join
    for (int c = 0; c < numChannels; c++)
      gUse[c] = 1'b0;
    idleGap();
    if (!holdCredit)
      waitDrain();
  endtask

  // Consumer and scoreboard on outputs registered before the edge
  always @(posedge clk)
  begin
    if (!reset)
    begin
      creditReturn <= 1'b0;
      if (outValid)
      begin
        matchIdx = findExpected(outChannel);
        if (matchIdx < 0)
        begin
          $display("Unexpected byte %h arrived on channel %0d", outData, outChannel);
          errorCount++;
        end
        else
        begin
          expEntry = expQ[matchIdx];
          if (outData !== expEntry[7:0] || outFrameError !== expEntry[8] ||
              outOverrun !== expEntry[9])
          begin
            $display("FAILED %s, record %0d: expected ch%0d data %h fe %b ov %b, %s %h fe %b ov %b",
                     testName(expEntry[15:12]), recQ[matchIdx], outChannel, expEntry[7:0],
                     expEntry[8], expEntry[9], "actual data", outData, outFrameError,
                     outOverrun);
            errorCount++;
          end
          expQ.delete(matchIdx);
          recQ.delete(matchIdx);
          checkedCount++;
        end
        if (outstanding >= creditLimit)
        begin
          $display("Byte delivered on channel %0d with no credit left", outChannel);
          errorCount++;
        end
        outstanding++;
      end
      if (!holdCredit && outstanding > 0)
      begin
        creditReturn <= 1'b1; // One credit per cycle
        outstanding--;
      end
    end
  end

  initial
  begin : mainSequence
    logic [23:0]            rec;
    logic [3:0]             op;
    logic [channelBits-1:0] ch;
    rxd          = '1;
    creditReturn = 1'b0;
    reset        = 1'b1;
    holdCredit   = 1'b0;
    outstanding  = 0;
    errorCount   = 0;
    checkedCount = 0;
    rngState     = 32'h29ef;
    for (int c = 0; c < numChannels; c++)
      gUse[c] = 1'b0;
    for (int i = 0; i < maxRecords; i++)
      records[i] = '0; // Op 0 ends the list
    $readmemh("verification/uartRxHub_testdata.txt", records);
    numRecords = 0;
    while (numRecords < maxRecords - 1 && records[numRecords][23:20] != 4'd0)
      numRecords++;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk);
    for (int r = 0; r < numRecords; r++)
    begin
      rec = records[r];
      op  = rec[23:20];
      ch  = rec[17:16];
      case (op)
        4'd1:
        begin
          pushExpected(rec, r);
          sendFrame(ch, rec[15:8], rec[4]);
          idleGap();
          if (!holdCredit)
            waitDrain();
        end
        4'd2:
        begin
          gUse[ch]  = 1'b1;
          gData[ch] = rec[15:8];
          gStop[ch] = rec[4];
          pushExpected(rec, r);
          // Group ends at a non-group record or a channel already taken
          if (records[r + 1][23:20] != 4'd2 || gUse[records[r + 1][17:16]])
            launchGroup();
        end
        4'd3:
        begin
          waitDrain();
          repeat (4) @(posedge clk); // Let returns in flight reach the collector
          holdCredit = 1'b1;
        end
        4'd4:
        begin
          if (expQ.size() > 0 && outstanding != creditLimit)
          begin
            $display("Credit hold let %0d bytes through instead of %0d",
                     outstanding, creditLimit);
            errorCount++;
          end
          holdCredit = 1'b0;
          waitDrain();
        end
        4'd5: sendGlitch(ch, rec[15:8]);
        default:
        begin
          $display("Unknown operation %h in record %0d", op, r);
          errorCount++;
        end
      endcase
    end
    waitDrain();
    repeat (2 * clocksPerBit) @(posedge clk); // Catch a late stray byte
    errorCount += i_uartRxHub.i_byteCollector.i_collectorProps.failCount; // Bound assertions
    $display("Closing: %0d errors, %0d bytes checked", errorCount, checkedCount);
    if (errorCount == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Watchdog allows about twelve bit periods per record
  initial
  begin : watchdog
    longint limitNs;
    #1;
    limitNs = longint'(numRecords * 12 + 60) * clocksPerBit * 20;
    #(limitNs);
    errorCount++;
    errorCount += i_uartRxHub.i_byteCollector.i_collectorProps.failCount;
    $display("Timeout after %0d ns, %0d bytes never arrived", limitNs, expQ.size());
    $display("Closing: %0d errors, %0d bytes checked", errorCount, checkedCount);
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== verification/uartRxHub_testdata.txt ====
// Columns in hex: op_channel_byte_stop_flags
// Op 1 frame, 2 concurrent group, 3 hold credit, 4 release credit, 5 glitch (byte = low cycles)
// Flags bit0 frame error, bit1 overrun, bit3 byte is dropped
1_0_A5_1_0
1_1_3C_1_0
1_2_00_1_0
1_3_FF_1_0
// Two groups started on all lines at once
2_0_11_1_0
2_1_22_1_0
2_2_33_1_0
2_3_44_1_0
2_0_55_1_0
2_1_66_1_0
2_2_77_1_0
2_3_88_1_0
// Low stop bit then a clean frame on the same line
1_1_C3_0_1
1_1_5A_1_0
// One cycle glitch and a pulse shorter than half a bit
5_2_01_1_0
5_2_05_1_0
// Credit runs out after four bytes, the fifth waits and the sixth is lost
3_0_00_0_0
1_0_01_1_0
1_1_02_1_0
1_2_03_1_0
1_3_04_1_0
1_0_E1_1_2
1_0_E2_1_8
4_0_00_0_0
1_3_96_1_0
